// ==== src/axi_lite_pkg.sv ====
// AXI4-Lite bus definitions.
// Widths, payload vector types and the response encoding shared by the slave.

package axi_lite_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------

    // Address width of the bus.
    localparam int AXI_ADDR_W = 32;

    // Data width of the bus.
    localparam int AXI_DATA_W = 32;

    // One strobe bit per data byte.
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // Lowest address bit that selects a 32-bit word.
    localparam int AXI_ADDR_LSB = 2;

    // ----------------------------------------------------------------------
    // Payload types
    // ----------------------------------------------------------------------

    // Byte address as seen on AWADDR and ARADDR.
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    // Data word as seen on WDATA and RDATA.
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    // Byte enables as seen on WSTRB.
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;

    // Response code on BRESP and RRESP.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

// ==== src/regmap_pkg.sv ====
// Register map definitions.
// Register count, word index, set-bit count and the internal command types.

package regmap_pkg;

    import axi_lite_pkg::*;

    // Number of 32-bit registers in the bank.
    localparam int NUM_REGS = 4;

    // Width of the word index taken from the address.
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // Index of one register.
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Set-bit count of one data word, 0 to 32 inclusive.
    typedef logic [$clog2(AXI_DATA_W):0] bit_cnt_t;

    // Write command from the write controller to the bank.
    // En is high for exactly one cycle per accepted write.
    typedef struct packed {
        logic      en;
        reg_idx_t  idx;
        axi_data_t data;
        axi_strb_t strb;
    } reg_wr_t;

    // All registers side by side, element 0 in the low word.
    typedef axi_data_t [NUM_REGS-1:0] reg_file_t;

endpackage

// ==== src/axi_lite_write_ctrl.sv ====
// AXI4-Lite write channel controller.
// Takes address and data together, issues one register write, returns the response.

`timescale 1ns/1ns

module axi_lite_write_ctrl import axi_lite_pkg::*, regmap_pkg::*; (
    input  logic      i_clk,
    input  logic      i_sync_rst,
    input  logic      i_awvalid,
    input  axi_addr_t i_awaddr,
    input  logic      i_wvalid,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    input  logic      i_bready,
    output logic      o_awready,
    output logic      o_wready,
    output logic      o_bvalid,
    output reg_wr_t   o_reg_wr
);

    // ----------------------------------------------------------------------
    // Control state
    // ----------------------------------------------------------------------

    // High while no write is in progress.
    logic     r_listen;
    // Shared AWREADY and WREADY pulse.
    logic     r_wr_ready;
    logic     r_bvalid;
    // Word index of the latched write address.
    reg_idx_t r_wr_idx;

    logic     g_latch_awaddr;
    logic     g_wr_fire;
    logic     g_b_taken;

    // Both valids seen while idle.
    assign g_latch_awaddr = r_listen && i_awvalid && i_wvalid;
    // Address and data handshakes complete on the same edge.
    assign g_wr_fire = r_wr_ready && i_awvalid && i_wvalid;
    assign g_b_taken = r_bvalid && i_bready;

    // Listen flag.
    // Cleared on address latch, set again once the response is taken.
    always_ff @(posedge i_clk) begin : listen_flag
        if (i_sync_rst) begin
            r_listen <= 1'b1;
        end else if (g_latch_awaddr) begin
            r_listen <= 1'b0;
        end else if (g_b_taken) begin
            r_listen <= 1'b1;
        end else if (r_wr_ready && !g_wr_fire) begin
            // Master withdrew its valids, so start over.
            r_listen <= 1'b1;
        end
    end

    // One-cycle ready pulse, the cycle after the latch.
    always_ff @(posedge i_clk) begin : gen_ready
        if (i_sync_rst) begin
            r_wr_ready <= 1'b0;
        end else begin
            r_wr_ready <= g_latch_awaddr;
        end
    end

    // Only the word index is kept from the address.
    always_ff @(posedge i_clk) begin : latch_awaddr
        if (g_latch_awaddr) begin
            r_wr_idx <= i_awaddr[AXI_ADDR_LSB +: REG_IDX_W];
        end
    end

    // Response rises with the register update, falls on BREADY.
    always_ff @(posedge i_clk) begin : gen_bvalid
        if (i_sync_rst) begin
            r_bvalid <= 1'b0;
        end else if (g_wr_fire) begin
            r_bvalid <= 1'b1;
        end else if (g_b_taken) begin
            r_bvalid <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    // Write command uses the data and strobes of the ready cycle.
    always_comb begin : form_reg_wr
        o_reg_wr.en   = g_wr_fire;
        o_reg_wr.idx  = r_wr_idx;
        o_reg_wr.data = i_wdata;
        o_reg_wr.strb = i_wstrb;
    end

    assign o_awready = r_wr_ready;
    assign o_wready  = r_wr_ready;
    assign o_bvalid  = r_bvalid;

endmodule

// ==== src/axi_lite_read_ctrl.sv ====
// AXI4-Lite read channel controller.
// Accepts one address at a time and holds the read data until it is taken.

`timescale 1ns/1ns

module axi_lite_read_ctrl import axi_lite_pkg::*, regmap_pkg::*; (
    input  logic      i_clk,
    input  logic      i_sync_rst,
    input  logic      i_arvalid,
    input  axi_addr_t i_araddr,
    input  logic      i_rready,
    input  reg_file_t i_regs,
    output logic      o_arready,
    output logic      o_rvalid,
    output axi_data_t o_rdata
);

    logic      r_arready;
    logic      r_rvalid;
    axi_data_t r_rdata;
    // Word index of the latched read address.
    reg_idx_t  r_rd_idx;

    logic      g_rd_accept;
    logic      g_rd_fire;
    logic      g_r_taken;

    // New address only while idle and no response is pending.
    assign g_rd_accept = i_arvalid && !r_arready && !r_rvalid;
    assign g_rd_fire   = r_arready && i_arvalid;
    assign g_r_taken   = r_rvalid && i_rready;

    // ARREADY pulse, with the address latched on the same edge.
    always_ff @(posedge i_clk) begin : gen_arready
        if (i_sync_rst) begin
            r_arready <= 1'b0;
        end else begin
            r_arready <= g_rd_accept;
        end
    end

    always_ff @(posedge i_clk) begin : latch_araddr
        if (g_rd_accept) begin
            r_rd_idx <= i_araddr[AXI_ADDR_LSB +: REG_IDX_W];
        end
    end

    // Response valid, held until RREADY.
    always_ff @(posedge i_clk) begin : gen_rvalid
        if (i_sync_rst) begin
            r_rvalid <= 1'b0;
        end else if (g_rd_fire) begin
            r_rvalid <= 1'b1;
        end else if (g_r_taken) begin
            r_rvalid <= 1'b0;
        end
    end

    // Addressed word captured at the end of the ARREADY cycle.
    always_ff @(posedge i_clk) begin : capture_rdata
        if (i_sync_rst) begin
            r_rdata <= '0;
        end else if (g_rd_fire) begin
            r_rdata <= i_regs[r_rd_idx];
        end
    end

    assign o_arready = r_arready;
    assign o_rvalid  = r_rvalid;
    assign o_rdata   = r_rdata;

endmodule

// ==== src/reg_bank.sv ====
// Register bank of four data words.
// Applies byte-strobed writes and shows every register at its output.

`timescale 1ns/1ns

module reg_bank import axi_lite_pkg::*, regmap_pkg::*; (
    input  logic      i_clk,
    input  logic      i_sync_rst,
    input  reg_wr_t   i_reg_wr,
    output reg_file_t o_regs
);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // All registers, element 0 in the low word.
    reg_file_t r_regs;

    // Byte-strobed write.
    // Only the indexed register changes, and in it only the strobed bytes.
    always_ff @(posedge i_clk) begin : write_regs
        if (i_sync_rst) begin
            r_regs <= '0;
        end else if (i_reg_wr.en) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (i_reg_wr.strb[b]) begin
                    r_regs[i_reg_wr.idx][b*8 +: 8] <= i_reg_wr.data[b*8 +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    // Whole bank feeds the read path and the summaries.
    assign o_regs = r_regs;

endmodule

// ==== src/reg_reductions.sv ====
// Per-register summaries.
// OR, AND and XOR reductions and a set-bit count, all combinational.

`timescale 1ns/1ns

module reg_reductions import axi_lite_pkg::*, regmap_pkg::*; (
    input  reg_file_t i_regs,
    output logic      o_reg_0_or,
    output logic      o_reg_1_and,
    output logic      o_reg_2_xor,
    output bit_cnt_t  o_reg_3_bit_cnt
);

    // Number of set bits in one data word.
    function automatic bit_cnt_t count_bits(input axi_data_t data);
        bit_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < AXI_DATA_W; i++) begin
            cnt += bit_cnt_t'(data[i]);
        end
        return cnt;
    endfunction

    // Any bit set in register 0.
    assign o_reg_0_or = |i_regs[0];
    // All bits set in register 1.
    assign o_reg_1_and = &i_regs[1];
    // Odd parity of register 2.
    assign o_reg_2_xor = ^i_regs[2];
    // Population count of register 3.
    assign o_reg_3_bit_cnt = count_bits(i_regs[3]);

endmodule

// ==== src/reg_reduce_slave.sv ====
// AXI4-Lite slave with four registers and their summary outputs.
// Connects the write and read controllers, the register bank and the reductions.

`timescale 1ns/1ns

module reg_reduce_slave import axi_lite_pkg::*, regmap_pkg::*; (
    input  logic      i_clk,
    input  logic      i_sync_rst,
    // Write address channel.
    input  logic      i_awvalid,
    input  axi_addr_t i_awaddr,
    output logic      o_awready,
    // Write data channel.
    input  logic      i_wvalid,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    output logic      o_wready,
    // Write response channel.
    output logic      o_bvalid,
    output axi_resp_t o_bresp,
    input  logic      i_bready,
    // Read address channel.
    input  logic      i_arvalid,
    input  axi_addr_t i_araddr,
    output logic      o_arready,
    // Read data channel.
    output logic      o_rvalid,
    output axi_data_t o_rdata,
    output axi_resp_t o_rresp,
    input  logic      i_rready,
    // Register summaries.
    output logic      o_reg_0_or,
    output logic      o_reg_1_and,
    output logic      o_reg_2_xor,
    output bit_cnt_t  o_reg_3_bit_cnt
);

    reg_wr_t   g_reg_wr;
    reg_file_t g_regs;

    // ----------------------------------------------------------------------
    // Bus side
    // ----------------------------------------------------------------------

    axi_lite_write_ctrl axi_lite_write_ctrl_i (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_awvalid  (i_awvalid),
        .i_awaddr   (i_awaddr),
        .i_wvalid   (i_wvalid),
        .i_wdata    (i_wdata),
        .i_wstrb    (i_wstrb),
        .i_bready   (i_bready),
        .o_awready  (o_awready),
        .o_wready   (o_wready),
        .o_bvalid   (o_bvalid),
        .o_reg_wr   (g_reg_wr)
    );

    axi_lite_read_ctrl axi_lite_read_ctrl_i (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_arvalid  (i_arvalid),
        .i_araddr   (i_araddr),
        .i_rready   (i_rready),
        .i_regs     (g_regs),
        .o_arready  (o_arready),
        .o_rvalid   (o_rvalid),
        .o_rdata    (o_rdata)
    );

    // Every index maps to a register, so no error response exists.
    assign o_bresp = RESP_OKAY;
    assign o_rresp = RESP_OKAY;

    // ----------------------------------------------------------------------
    // Register side
    // ----------------------------------------------------------------------

    reg_bank reg_bank_i (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_reg_wr   (g_reg_wr),
        .o_regs     (g_regs)
    );

    reg_reductions reg_reductions_i (
        .i_regs          (g_regs),
        .o_reg_0_or      (o_reg_0_or),
        .o_reg_1_and     (o_reg_1_and),
        .o_reg_2_xor     (o_reg_2_xor),
        .o_reg_3_bit_cnt (o_reg_3_bit_cnt)
    );

endmodule

// ==== verification/reg_reduce_slave_props.sv ====
// Protocol properties of the AXI4-Lite register slave.
// Bound to the top level and checks the handshake rules on every clock.

`timescale 1ns/1ns

module reg_reduce_slave_props (
    input logic i_clk,
    input logic i_sync_rst,
    input logic o_awready,
    input logic o_wready,
    input logic o_bvalid,
    input logic i_bready,
    input logic o_arready,
    input logic o_rvalid,
    input logic i_rready
);

    // Number of property failures seen so far.
    int assert_failures = 0;

    // ----------------------------------------------------------------------
    // Write channel rules
    // ----------------------------------------------------------------------

    // Address and data are accepted together.
    ready_pair_equal: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_awready == o_wready)
        else begin
            assert_failures++;
            $error("AWREADY and WREADY differ");
        end

    // Each ready is a single-cycle pulse.
    awready_pulse: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_awready |=> !o_awready)
        else begin
            assert_failures++;
            $error("AWREADY stayed high for more than one cycle");
        end

    wready_pulse: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_wready |=> !o_wready)
        else begin
            assert_failures++;
            $error("WREADY stayed high for more than one cycle");
        end

    // Response is held until taken.
    bvalid_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_bvalid && !i_bready |=> o_bvalid)
        else begin
            assert_failures++;
            $error("BVALID dropped before BREADY");
        end

    // ----------------------------------------------------------------------
    // Read channel rules
    // ----------------------------------------------------------------------

    rvalid_hold: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        o_rvalid && !i_rready |=> o_rvalid)
        else begin
            assert_failures++;
            $error("RVALID dropped before RREADY");
        end

    // No new address while a read response is pending.
    arready_idle: assert property (@(posedge i_clk) disable iff (i_sync_rst)
        !(o_arready && o_rvalid))
        else begin
            assert_failures++;
            $error("ARREADY high while RVALID is pending");
        end

endmodule

bind reg_reduce_slave reg_reduce_slave_props reg_reduce_slave_props_i (
    .i_clk      (i_clk),
    .i_sync_rst (i_sync_rst),
    .o_awready  (o_awready),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready)
);

// ==== verification/reg_reduce_slave_tb.sv ====
// Testbench of the AXI4-Lite register slave.
// Random writes and reads against a register model, with summary and handshake checks.

`timescale 1ns/1ns

module reg_reduce_slave_tb import axi_lite_pkg::*, regmap_pkg::*; ();

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 8;
    localparam int NUM_TRANS        = 200;
    localparam int CYCLES_PER_TRANS = 20;
    localparam int HS_LIMIT         = 16;
    localparam int WATCHDOG_NS      = NUM_TRANS * CYCLES_PER_TRANS * CLK_PERIOD
                                      + RESET_CYCLES * CLK_PERIOD;

    logic      i_clk = 1'b0;
    logic      i_sync_rst;
    logic      i_awvalid;
    axi_addr_t i_awaddr;
    logic      o_awready;
    logic      i_wvalid;
    axi_data_t i_wdata;
    axi_strb_t i_wstrb;
    logic      o_wready;
    logic      o_bvalid;
    axi_resp_t o_bresp;
    logic      i_bready;
    logic      i_arvalid;
    axi_addr_t i_araddr;
    logic      o_arready;
    logic      o_rvalid;
    axi_data_t o_rdata;
    axi_resp_t o_rresp;
    logic      i_rready;
    logic      o_reg_0_or;
    logic      o_reg_1_and;
    logic      o_reg_2_xor;
    bit_cnt_t  o_reg_3_bit_cnt;

    // Register model and run statistics.
    axi_data_t model_regs [NUM_REGS];
    int checks = 0;
    int value_errors = 0;
    int handshake_errors = 0;
    int writes_issued = 0;
    int reads_issued = 0;
    int write_responses = 0;
    int read_responses = 0;

    // Previous response valids, for edge detection.
    logic prev_bvalid = 1'b0;
    logic prev_rvalid = 1'b0;

    reg_reduce_slave reg_reduce_slave_i (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Response monitor.
    // Each rising BVALID or RVALID counts as one response from the DUT.
    always @(posedge i_clk) begin : count_responses
        if (o_bvalid && !prev_bvalid) begin
            write_responses++;
        end
        if (o_rvalid && !prev_rvalid) begin
            read_responses++;
        end
        prev_bvalid <= o_bvalid;
        prev_rvalid <= o_rvalid;
    end

    // ----------------------------------------------------------------------
    // Model and check helpers
    // ----------------------------------------------------------------------

    // Strobed bytes come from the new word, the others stay.
    function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                              input axi_data_t new_word,
                                              input axi_strb_t strb);
        axi_data_t mask;
        mask = '0;
        for (int b = 0; b < AXI_STRB_W; b++) begin
            if (strb[b]) begin
                mask[b*8 +: 8] = 8'hFF;
            end
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Set bits, clearing the lowest one per step.
    function automatic int count_ones(input axi_data_t word);
        axi_data_t rest;
        int n;
        rest = word;
        n = 0;
        while (rest != '0) begin
            rest = rest & (rest - 1);
            n++;
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            value_errors++;
            $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_summaries();
        compare_value("o_reg_0_or", 32'(model_regs[0] != '0), 32'(o_reg_0_or));
        compare_value("o_reg_1_and", 32'(model_regs[1] == '1), 32'(o_reg_1_and));
        compare_value("o_reg_2_xor", 32'(count_ones(model_regs[2]) % 2), 32'(o_reg_2_xor));
        compare_value("o_reg_3_bit_cnt", 32'(count_ones(model_regs[3])),
                      32'(o_reg_3_bit_cnt));
    endtask

    // Random address bits around the word index.
    function automatic axi_addr_t make_addr(input reg_idx_t idx);
        axi_addr_t addr;
        addr = axi_addr_t'($urandom);
        addr[AXI_ADDR_LSB +: REG_IDX_W] = idx;
        return addr;
    endfunction

    task automatic print_error_counts();
        $display("Checks %0d, value errors %0d, handshake errors %0d, property errors %0d",
                 checks, value_errors, handshake_errors,
                 reg_reduce_slave_i.reg_reduce_slave_props_i.assert_failures);
    endtask

    // ----------------------------------------------------------------------
    // Bus transactions, entered just after a falling edge
    // ----------------------------------------------------------------------

    task automatic write_reg(input reg_idx_t idx, input axi_data_t data,
                             input axi_strb_t strb);
        int wait_cycles;
        int delay;
        delay = int'($urandom_range(3));
        writes_issued++;
        i_awvalid = 1'b1;
        i_awaddr  = make_addr(idx);
        i_wvalid  = 1'b1;
        i_wdata   = data;
        i_wstrb   = strb;
        wait_cycles = 0;
        do begin
            @(negedge i_clk);
            wait_cycles++;
        end while (!o_awready && wait_cycles < HS_LIMIT);
        assert (wait_cycles == 1 && o_awready)
        else begin
            handshake_errors++;
            $display("Write address was not accepted one cycle after the valids");
        end
        compare_value("o_wready", 32'h1, 32'(o_wready));
        // Register takes the write at the coming rising edge.
        model_regs[idx] = merge_bytes(model_regs[idx], data, strb);
        @(negedge i_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        compare_value("o_bvalid", 32'h1, 32'(o_bvalid));
        compare_value("o_bresp", 32'(RESP_OKAY), 32'(o_bresp));
        check_summaries();
        repeat (delay) begin
            @(negedge i_clk);
            compare_value("o_bvalid", 32'h1, 32'(o_bvalid));
        end
        i_bready = 1'b1;
        @(negedge i_clk);
        i_bready = 1'b0;
        // Response taken once, so it must be gone.
        compare_value("o_bvalid", 32'h0, 32'(o_bvalid));
    endtask

    task automatic read_reg(input reg_idx_t idx);
        int wait_cycles;
        int delay;
        axi_data_t expected;
        delay = int'($urandom_range(3));
        expected = model_regs[idx];
        reads_issued++;
        i_arvalid = 1'b1;
        i_araddr  = make_addr(idx);
        wait_cycles = 0;
        do begin
            @(negedge i_clk);
            wait_cycles++;
        end while (!o_arready && wait_cycles < HS_LIMIT);
        assert (wait_cycles == 1 && o_arready)
        else begin
            handshake_errors++;
            $display("Read address was not accepted one cycle after ARVALID");
        end
        @(negedge i_clk);
        i_arvalid = 1'b0;
        compare_value("o_rvalid", 32'h1, 32'(o_rvalid));
        compare_value("o_rdata", expected, o_rdata);
        compare_value("o_rresp", 32'(RESP_OKAY), 32'(o_rresp));
        repeat (delay) begin
            @(negedge i_clk);
            compare_value("o_rvalid", 32'h1, 32'(o_rvalid));
            compare_value("o_rdata", expected, o_rdata);
        end
        i_rready = 1'b1;
        @(negedge i_clk);
        i_rready = 1'b0;
        compare_value("o_rvalid", 32'h0, 32'(o_rvalid));
    endtask

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------

    initial begin : watchdog
        #(WATCHDOG_NS);
        handshake_errors++;
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_error_counts();
        $display("Test failures found");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin : stimulus
        reg_idx_t  idx;
        axi_data_t data;
        axi_strb_t strb;
        void'($urandom(32'h8109));
        i_sync_rst = 1'b1;
        i_awvalid  = 1'b0;
        i_awaddr   = '0;
        i_wvalid   = 1'b0;
        i_wdata    = '0;
        i_wstrb    = '0;
        i_bready   = 1'b0;
        i_arvalid  = 1'b0;
        i_araddr   = '0;
        i_rready   = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_sync_rst = 1'b0;

        // Idle outputs and cleared registers.
        compare_value("o_awready", 32'h0, 32'(o_awready));
        compare_value("o_wready", 32'h0, 32'(o_wready));
        compare_value("o_bvalid", 32'h0, 32'(o_bvalid));
        compare_value("o_arready", 32'h0, 32'(o_arready));
        compare_value("o_rvalid", 32'h0, 32'(o_rvalid));
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(reg_idx_t'(i));
        end

        // Full-word write and read back per register.
        for (int i = 0; i < NUM_REGS; i++) begin
            write_reg(reg_idx_t'(i), axi_data_t'($urandom), 4'hF);
            read_reg(reg_idx_t'(i));
        end

        // Partial strobes, then the bit-count corners.
        write_reg(2'd2, axi_data_t'($urandom), 4'b0101);
        read_reg(2'd2);
        write_reg(2'd1, axi_data_t'($urandom), 4'b1000);
        read_reg(2'd1);
        write_reg(2'd3, 32'h0000_0000, 4'hF);
        write_reg(2'd3, 32'hFFFF_FFFF, 4'hF);
        write_reg(2'd1, 32'hFFFF_FFFF, 4'hF);

        // Random traffic.
        for (int t = 0; t < NUM_TRANS; t++) begin
            idx  = reg_idx_t'($urandom_range(NUM_REGS - 1));
            data = axi_data_t'($urandom);
            strb = axi_strb_t'($urandom);
            if ($urandom_range(1) == 1) begin
                write_reg(idx, data, strb);
            end else begin
                read_reg(idx);
            end
        end

        // Exactly one response per transaction.
        assert (write_responses == writes_issued && read_responses == reads_issued)
        else begin
            handshake_errors++;
            $display("Responses do not match the issued writes and reads");
        end

        print_error_counts();
        if (value_errors == 0 && handshake_errors == 0
            && reg_reduce_slave_i.reg_reduce_slave_props_i.assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/axi_lite_pkg.sv
src/regmap_pkg.sv
src/axi_lite_write_ctrl.sv
src/axi_lite_read_ctrl.sv
src/reg_bank.sv
src/reg_reductions.sv
src/reg_reduce_slave.sv
verification/reg_reduce_slave_props.sv
verification/reg_reduce_slave_tb.sv

// ==== Makefile ====
TOP := reg_reduce_slave_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
